//--- rtl/rv_core_pkg.sv
/*
 * Shared widths, encodings and packed structs of the RV32I subset core.
 * Modules pull this in by a wildcard import in their headers.
 */
`default_nettype none

package rv_core_pkg;

   parameter int XLEN   = 32;  // data and register width
   parameter int REG_AW = 5;   // register index width

   // ----------------------------------------
   // encodings
   // ----------------------------------------
   typedef enum logic [6:0] {
      OP_ALUREG = 7'b0110011,
      OP_ALUIMM = 7'b0010011,
      OP_LUI    = 7'b0110111,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_NOP    = 7'b0000000   // anything else, only bumps the pc
   } opcode_e;

   typedef enum logic [2:0] {
      LS_B  = 3'b000,
      LS_H  = 3'b001,
      LS_W  = 3'b010,
      LS_BU = 3'b100,
      LS_HU = 3'b101
   } funct3_ls_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_EXECUTE,
      ST_ACCESS
   } state_e;

   typedef logic [3:0] byte_en_t;  // bit n covers bits 8n+7:8n

   // ----------------------------------------
   // structs
   // ----------------------------------------
   typedef struct packed {
      opcode_e           op;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      funct3_ls_e        width;    // load/store size and sign
      alu_op_e           alu_op;
      logic              use_imm;  // second operand from imm
      logic [XLEN-1:0]   imm;
   } decode_t;

   typedef struct packed {
      logic [XLEN-1:0] addr;  // byte address
      byte_en_t        we;    // zero for loads
      logic [XLEN-1:0] wdat;  // lane-replicated store data
   } dmem_req_t;

endpackage

`default_nettype wire

//--- rtl/rv_regfile.sv
/*
 * 32x32 register file, two asynchronous read ports, one write port.
 * x0 is not stored and always reads zero.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
   input  logic              clk,
   input  logic [REG_AW-1:0] rs1,
   input  logic [REG_AW-1:0] rs2,
   input  logic [REG_AW-1:0] rd,
   input  logic              rf_we,
   input  logic [XLEN-1:0]   rf_wdat,
   output logic [XLEN-1:0]   rs1_dat,
   output logic [XLEN-1:0]   rs2_dat
);

   logic [XLEN-1:0] regs [1:31];  // x1..x31 only

   always_ff @(posedge clk) begin
      if (rf_we && rd != '0) regs[rd] <= rf_wdat;
   end

   assign rs1_dat = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_dat = (rs2 == '0) ? '0 : regs[rs2];

   // a write aimed at x0 changes no read value
   a_x0_write_ignored: assert property (@(posedge clk)
      (rf_we && rd == '0) ##1 ($stable(rs1) && $stable(rs2))
      |-> $stable(rs1_dat) && $stable(rs2_dat));

endmodule

`default_nettype wire

//--- rtl/rv_alu.sv
/*
 * Combinational ALU for the kept register and immediate operations.
 * Operand b comes from rs2 or the decoded immediate.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_core_pkg::*; (
   input  decode_t         dec,
   input  logic [XLEN-1:0] rs1_dat,
   input  logic [XLEN-1:0] rs2_dat,
   output logic [XLEN-1:0] alu_res
);

   logic [XLEN-1:0] op_b;

   assign op_b = dec.use_imm ? dec.imm : rs2_dat;  // ALUIMM takes imm

   always_comb begin
      unique case (dec.alu_op)
         ALU_ADD: alu_res = rs1_dat + op_b;
         ALU_SUB: alu_res = rs1_dat - op_b;
         ALU_AND: alu_res = rs1_dat & op_b;
         ALU_OR:  alu_res = rs1_dat | op_b;
         ALU_XOR: alu_res = rs1_dat ^ op_b;
         default: alu_res = rs1_dat + op_b;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
/*
 * Instruction register and decoder.
 * The word is latched at the end of the fetch cycle and held until the
 * next fetch, so dec stays stable through execute and access.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_core_pkg::*; (
   input  logic            clk,
   input  logic            arst_n,
   input  logic [XLEN-1:0] imem_rdat,
   input  logic            load_instr,  // high in fetch
   output decode_t         dec
);

   logic [XLEN-1:0] instr_q;
   logic [2:0]      funct3;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) instr_q <= '0;  // zero word decodes as a no-op
      else if (load_instr) instr_q <= imem_rdat;
   end

   assign funct3 = instr_q[14:12];

   always_comb begin
      dec         = '0;
      dec.rd      = instr_q[11:7];
      dec.rs1     = instr_q[19:15];
      dec.rs2     = instr_q[24:20];
      dec.use_imm = (instr_q[6:0] == OP_ALUIMM);

      // opcode class, unknown ones fall to nop
      case (instr_q[6:0])
         OP_ALUREG, OP_ALUIMM, OP_LUI, OP_LOAD, OP_STORE: dec.op = opcode_e'(instr_q[6:0]);
         default: dec.op = OP_NOP;
      endcase

      case (funct3)
         3'b000:  dec.width = LS_B;
         3'b001:  dec.width = LS_H;
         3'b100:  dec.width = LS_BU;
         3'b101:  dec.width = LS_HU;
         default: dec.width = LS_W;
      endcase

      case (funct3)
         3'b000:  dec.alu_op = (dec.op == OP_ALUREG && instr_q[30]) ? ALU_SUB : ALU_ADD;
         3'b100:  dec.alu_op = ALU_XOR;
         3'b110:  dec.alu_op = ALU_OR;
         3'b111:  dec.alu_op = ALU_AND;
         default: dec.alu_op = ALU_ADD;  // shifts and compares not kept
      endcase

      // immediate per format
      case (dec.op)
         OP_STORE: dec.imm = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
         OP_LUI:   dec.imm = {instr_q[31:12], 12'd0};
         default:  dec.imm = {{20{instr_q[31]}}, instr_q[31:20]};  // I-type
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/rv_lsu.sv
/*
 * Load/store unit. Forms the byte address, lane data and byte enable,
 * registers them onto the data port on issue, and extracts the load
 * value from read data captured at the end of the access.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu import rv_core_pkg::*; (
   input  logic            clk,
   input  logic            arst_n,
   input  decode_t         dec,
   input  logic [XLEN-1:0] rs1_dat,
   input  logic [XLEN-1:0] rs2_dat,
   input  logic            issue,    // one cycle, in execute
   input  logic            capture,  // load completes
   input  logic [XLEN-1:0] dmem_rdat,
   output dmem_req_t       dmem_req,
   output logic [XLEN-1:0] load_dat
);

   logic [XLEN-1:0] addr_d, wdat_d;
   byte_en_t        be_d;
   logic [XLEN-1:0] addr_q, wdat_q, rdat_q, rdat_sh;
   byte_en_t        we_q;

   // ----------------------------------------
   // store lanes
   // ----------------------------------------
   assign addr_d = rs1_dat + dec.imm;

   always_comb begin
      wdat_d = rs2_dat;
      be_d   = '0;                          // loads never write
      if (dec.op == OP_STORE) begin
         case (dec.width)
            LS_B: begin
               wdat_d = {4{rs2_dat[7:0]}};
               be_d   = byte_en_t'(4'b0001 << addr_d[1:0]);
            end
            LS_H: begin
               wdat_d = {2{rs2_dat[15:0]}};
               be_d   = addr_d[1] ? 4'b1100 : 4'b0011;
            end
            LS_W:    be_d = 4'b1111;
            default: be_d = '0;             // no such store
         endcase
      end
   end

   // address and data held for the whole access
   always_ff @(posedge clk) begin
      if (issue) begin
         addr_q <= addr_d;
         wdat_q <= wdat_d;
      end
   end

   // enable lives only in the cycle after issue
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) we_q <= '0;
      else we_q <= issue ? be_d : '0;
   end

   assign dmem_req = '{addr: addr_q, we: we_q, wdat: wdat_q};

   // ----------------------------------------
   // load extraction
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (capture) rdat_q <= dmem_rdat;
   end

   assign rdat_sh = rdat_q >> {addr_q[1:0], 3'b000};  // addressed byte to bit 0

   always_comb begin
      case (dec.width)
         LS_B:    load_dat = {{24{rdat_sh[7]}}, rdat_sh[7:0]};
         LS_BU:   load_dat = {24'd0, rdat_sh[7:0]};
         LS_H:    load_dat = {{16{rdat_sh[15]}}, rdat_sh[15:0]};
         LS_HU:   load_dat = {16'd0, rdat_sh[15:0]};
         default: load_dat = rdat_q;
      endcase
   end

   a_we_legal: assert property (@(posedge clk) disable iff (!arst_n)
      dmem_req.we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                          4'b0011, 4'b1100, 4'b1111});

endmodule

`default_nettype wire

//--- rtl/rv_ctrl.sv
/*
 * Control FSM: fetch, execute, access. Holds the pc, issues data
 * requests and picks the register writeback value. A load's write
 * lands in the fetch cycle right after its read data is captured.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl import rv_core_pkg::*; #(
   parameter int IMEM_AW = 10
) (
   input  logic               clk,
   input  logic               arst_n,
   input  decode_t            dec,
   input  logic               dmem_rdy,
   input  logic [XLEN-1:0]    alu_res,
   input  logic [XLEN-1:0]    load_dat,
   output logic [IMEM_AW-1:0] imem_addr,
   output logic               imem_vld,
   output logic               load_instr,
   output logic               issue,
   output logic               capture,
   output logic               dmem_vld,
   output logic               rf_we,
   output logic [XLEN-1:0]    rf_wdat
);

   state_e             state;
   logic [IMEM_AW-1:0] pc;
   logic               is_ls, ld_wb_q;

   assign is_ls = (dec.op == OP_LOAD) || (dec.op == OP_STORE);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= ST_FETCH;
         pc      <= '0;
         ld_wb_q <= 1'b0;
      end else begin
         ld_wb_q <= capture;  // write back one cycle later
         case (state)
            ST_FETCH: state <= ST_EXECUTE;
            ST_EXECUTE: begin
               pc    <= pc + 1'b1;                   // no branches, pc only counts
               state <= is_ls ? ST_ACCESS : ST_FETCH;
            end
            ST_ACCESS: begin
               if (dec.op == OP_STORE || dmem_rdy) state <= ST_FETCH;  // stores never wait
            end
            default: state <= ST_FETCH;
         endcase
      end
   end

   assign imem_addr  = pc;
   assign imem_vld   = (state == ST_FETCH);
   assign load_instr = (state == ST_FETCH);
   assign issue      = (state == ST_EXECUTE) && is_ls;
   assign dmem_vld   = (state == ST_ACCESS);
   assign capture    = (state == ST_ACCESS) && (dec.op == OP_LOAD) && dmem_rdy;

   // writeback select, dec still holds the load during the next fetch
   assign rf_we = ((state == ST_EXECUTE)
                   && (dec.op inside {OP_ALUREG, OP_ALUIMM, OP_LUI})) || ld_wb_q;

   always_comb begin
      case (dec.op)
         OP_LUI:  rf_wdat = dec.imm;
         OP_LOAD: rf_wdat = load_dat;
         default: rf_wdat = alu_res;
      endcase
   end

   // an access window only opens through issue
   a_vld_after_issue: assert property (@(posedge clk) disable iff (!arst_n)
      dmem_vld |-> $past(issue) || $past(dmem_vld));

   a_state_legal: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown(state) && state inside {ST_FETCH, ST_EXECUTE, ST_ACCESS});

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
/*
 * Top level of the multi-cycle RV32I subset core.
 * Instruction memory must answer within the fetch cycle; the data port
 * uses plain vld/rdy levels, only loads wait on dmem_rdy.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; #(
   parameter int IMEM_AW = 10  // word-addressed pc width
) (
   input  logic               clk,
   input  logic               arst_n,
   // instruction memory
   output logic [IMEM_AW-1:0] imem_addr,
   input  logic [XLEN-1:0]    imem_rdat,
   output logic               imem_vld,
   // data memory
   output logic [XLEN-1:0]    dmem_addr,
   output byte_en_t           dmem_we,
   output logic [XLEN-1:0]    dmem_wdat,
   input  logic [XLEN-1:0]    dmem_rdat,
   input  logic               dmem_rdy,
   output logic               dmem_vld
);

   decode_t         dec;
   dmem_req_t       dmem_req;
   logic [XLEN-1:0] rs1_dat, rs2_dat, alu_res, load_dat, rf_wdat;
   logic            load_instr, issue, capture, rf_we;

   rv_decode u_decode (
      .clk, .arst_n, .imem_rdat, .load_instr, .dec
   );

   rv_regfile u_regfile (
      .clk, .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
      .rf_we, .rf_wdat, .rs1_dat, .rs2_dat
   );

   rv_alu u_alu (
      .dec, .rs1_dat, .rs2_dat, .alu_res
   );

   rv_lsu u_lsu (
      .clk, .arst_n, .dec, .rs1_dat, .rs2_dat, .issue, .capture,
      .dmem_rdat, .dmem_req, .load_dat
   );

   rv_ctrl #(.IMEM_AW(IMEM_AW)) u_ctrl (
      .clk, .arst_n, .dec, .dmem_rdy, .alu_res, .load_dat,
      .imem_addr, .imem_vld, .load_instr, .issue, .capture, .dmem_vld,
      .rf_we, .rf_wdat
   );

   // request fields straight off the lsu registers
   assign dmem_addr = dmem_req.addr;
   assign dmem_we   = dmem_req.we;
   assign dmem_wdat = dmem_req.wdat;

endmodule

`default_nettype wire

//--- verif/tb_ref_model.svh
/*
 * Instruction-level model of the kept RV32I subset, included into the
 * testbench. Walks the program in imem, updates ref_mem and queues
 * every store, in program order, onto exp_q.
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic void run_ref_model();
   logic [XLEN-1:0] x [32];
   logic [XLEN-1:0] ins, a, b, res, addr, word, wd;
   byte_en_t        be;
   int              pc;
   for (pc = 0; pc < 32; pc++)
      x[pc] = '0;
   for (pc = 0; pc < prog_len; pc++) begin
      ins = imem[pc];
      a   = x[ins[19:15]];
      b   = x[ins[24:20]];
      res = x[ins[11:7]];                       // kept unless written
      case (ins[6:0])
         7'b0110011, 7'b0010011: begin
            if (!ins[5]) b = {{20{ins[31]}}, ins[31:20]};  // immediate form
            case (ins[14:12])
               3'b000:  res = (ins[5] && ins[30]) ? a - b : a + b;
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               3'b111:  res = a & b;
               default: res = a + b;
            endcase
         end
         7'b0110111: res = {ins[31:12], 12'h000};  // lui
         7'b0000011: begin
            addr = a + {{20{ins[31]}}, ins[31:20]};
            word = ref_mem[addr[7:2]] >> (8 * addr[1:0]);
            case (ins[14:12])
               3'b000:  res = {{24{word[7]}}, word[7:0]};
               3'b100:  res = {24'h0, word[7:0]};
               3'b001:  res = {{16{word[15]}}, word[15:0]};
               3'b101:  res = {16'h0, word[15:0]};
               default: res = word;
            endcase
         end
         7'b0100011: begin
            addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            be   = 4'b1111;
            wd   = b;
            if (ins[14:12] == 3'b000) begin      // sb, byte on every lane
               be = 4'b0001 << addr[1:0];
               wd = {4{b[7:0]}};
            end else if (ins[14:12] == 3'b001) begin
               be = addr[1] ? 4'b1100 : 4'b0011;
               wd = {2{b[15:0]}};
            end
            for (int k = 0; k < 4; k++)
               if (be[k]) ref_mem[addr[7:2]][8*k +: 8] = wd[8*k +: 8];
            exp_q.push_back('{addr: addr, be: be, wdat: wd});
         end
         default: ;                              // no-op
      endcase
      x[ins[11:7]] = res;
      x[0]         = '0;                         // x0 hardwired
   end
endfunction

`endif

//--- verif/tb_rv_core.sv
/*
 * Testbench for the RV32I subset core. Runs a fixed program from a
 * word-addressed instruction memory, answers loads after a random delay
 * and checks each store on the data port against the reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

   localparam int IMEM_AW    = 10;
   localparam int DMEM_WORDS = 64;  // byte addresses 0x00..0xff

   typedef struct packed {
      logic [XLEN-1:0] addr;
      byte_en_t        be;
      logic [XLEN-1:0] wdat;
   } exp_store_t;

   logic               clk, arst_n, imem_vld, dmem_rdy, dmem_vld, ld_busy;
   logic [IMEM_AW-1:0] imem_addr;
   logic [XLEN-1:0]    imem_rdat, dmem_addr, dmem_wdat, dmem_rdat;
   byte_en_t           dmem_we;
   logic [XLEN-1:0]    imem [2**IMEM_AW];
   logic [XLEN-1:0]    dmem [DMEM_WORDS];
   logic [XLEN-1:0]    ref_mem [DMEM_WORDS];
   exp_store_t         exp_q [$];
   int                 prog_len, ld_cnt, n_seen, cycles, seed, ld_wait;

   `include "tb_ref_model.svh"

   rv_core #(.IMEM_AW(IMEM_AW)) DUT (
      .clk, .arst_n, .imem_addr, .imem_rdat, .imem_vld,
      .dmem_addr, .dmem_we, .dmem_wdat, .dmem_rdat, .dmem_rdy, .dmem_vld
   );

   assign imem_rdat = imem[imem_addr];  // answers inside the fetch cycle

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cycles <= cycles + 1;

   // ----------------------------------------
   // encoders and program
   // ----------------------------------------
   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   task automatic put_instr(input logic [31:0] w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   // load from word ld_cnt at byte off, store the result above the base
   task automatic load_and_store(input logic [2:0] f3, input int off);
      put_instr(i_type(12'(4 * ld_cnt + off), 5'd0, f3, 5'd12, 7'b0000011));
      put_instr(s_type(12'(48 + 4 * ld_cnt), 5'd12, 5'd1, 3'b010));
      ld_cnt++;
   endtask

   task automatic build_program();
      int i;
      put_instr(i_type(12'h080, 5'd0, 3'b000, 5'd1, 7'b0010011));   // x1 store base
      put_instr({20'h12345, 5'd2, 7'b0110111});                      // lui x2
      put_instr(i_type(12'h678, 5'd2, 3'b000, 5'd2, 7'b0010011));   // x2 = 0x12345678
      put_instr(s_type(12'd0, 5'd2, 5'd1, 3'b010));
      put_instr(i_type(12'hffb, 5'd0, 3'b000, 5'd3, 7'b0010011));   // x3 = -5
      put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));           // add
      put_instr(r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd5));           // sub
      put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd6));           // and
      put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd7));           // or
      put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd8));           // xor
      put_instr(i_type(12'h0f0, 5'd2, 3'b111, 5'd9, 7'b0010011));   // andi
      put_instr(i_type(12'h123, 5'd3, 3'b110, 5'd10, 7'b0010011));  // ori
      put_instr(i_type(12'hfff, 5'd2, 3'b100, 5'd11, 7'b0010011));  // xori -1
      put_instr(r_type(7'h00, 5'd2, 5'd2, 3'b000, 5'd0));           // write aimed at x0
      for (i = 4; i <= 11; i++)
         put_instr(s_type(12'(4 * (i - 3)), 5'(i), 5'd1, 3'b010));
      put_instr(s_type(12'd36, 5'd0, 5'd1, 3'b010));                // x0 reads zero
      for (i = 0; i < 4; i++)
         put_instr(s_type(12'(40 + i), 5'd2, 5'd1, 3'b000));        // sb, every lane
      put_instr(s_type(12'd44, 5'd3, 5'd1, 3'b001));                // sh low half
      put_instr(s_type(12'd46, 5'd3, 5'd1, 3'b001));                // sh high half
      for (i = 0; i < 4; i++) begin
         load_and_store(3'b000, i);  // lb
         load_and_store(3'b100, i);  // lbu
      end
      for (i = 0; i < 4; i += 2) begin
         load_and_store(3'b001, i);  // lh
         load_and_store(3'b101, i);  // lhu
      end
      load_and_store(3'b010, 0);     // lw
   endtask

   // ----------------------------------------
   // data memory model
   // ----------------------------------------
   always @(negedge clk) begin
      if (dmem_vld && dmem_we != '0) begin
         for (int k = 0; k < 4; k++)
            if (dmem_we[k]) dmem[dmem_addr[7:2]][8*k +: 8] = dmem_wdat[8*k +: 8];
         dmem_rdy = 1'b0;
      end else if (dmem_vld) begin
         if (!ld_busy) begin
            ld_busy = 1'b1;
            ld_wait = $unsigned($random(seed)) % 4;  // 0 to 3 wait cycles
         end
         if (ld_wait == 0) begin
            dmem_rdy  = 1'b1;
            dmem_rdat = dmem[dmem_addr[7:2]];
            ld_busy   = 1'b0;
         end else begin
            dmem_rdy = 1'b0;
            ld_wait--;
         end
      end else begin
         dmem_rdy = 1'b0;
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_port_idle();
      assert (dmem_vld == 1'b0)
         else fail_run($sformatf("ERROR: dmem_vld = %h, expected 0", dmem_vld));
      assert (dmem_we == '0)
         else fail_run($sformatf("ERROR: dmem_we = %h, expected 0", dmem_we));
   endtask

   always @(negedge clk) begin : compare_stores
      exp_store_t e;
      if (arst_n && dmem_vld && dmem_we != '0) begin
         assert (n_seen < exp_q.size())
            else fail_run("a store appeared after the last expected one");
         e = exp_q[n_seen];
         assert (dmem_addr == e.addr)
            else fail_run($sformatf("ERROR: dmem_addr = %h, expected %h", dmem_addr, e.addr));
         assert (dmem_we == e.be)
            else fail_run($sformatf("ERROR: dmem_we = %h, expected %h", dmem_we, e.be));
         assert (dmem_wdat == e.wdat)
            else fail_run($sformatf("ERROR: dmem_wdat = %h, expected %h", dmem_wdat, e.wdat));
         n_seen++;
      end
   end

   initial begin
      arst_n    = 1'b0;
      dmem_rdy  = 1'b0;
      dmem_rdat = '0;
      ld_busy   = 1'b0;
      ld_wait   = 0;
      prog_len  = 0;
      ld_cnt    = 0;
      n_seen    = 0;
      cycles    = 0;
      seed      = 12458;
      for (int i = 0; i < 2**IMEM_AW; i++)
         imem[i] = '0;                            // zero word is a no-op
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i]    = $random(seed);
         ref_mem[i] = dmem[i];
      end
      build_program();
      run_ref_model();

      repeat (3) begin
         @(negedge clk);
         check_port_idle();
      end
      arst_n = 1'b1;
      assert (imem_vld == 1'b1)
         else fail_run($sformatf("ERROR: imem_vld = %h, expected 1 on first fetch", imem_vld));
      assert (imem_addr == '0)
         else fail_run($sformatf("ERROR: imem_addr = %h, expected 0 on first fetch", imem_addr));
      @(negedge clk);
      check_port_idle();                          // first cycle out of reset

      // up to 7 cycles per load, 8 per instruction leaves slack
      while (n_seen < exp_q.size() && cycles < 8 * prog_len + 100)
         @(posedge clk);
      if (n_seen == exp_q.size()) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         fail_run($sformatf("timeout after %0d cycles, %0d of %0d stores seen",
                            cycles, n_seen, exp_q.size()));
      end
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+verif
rtl/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_decode.sv
rtl/rv_lsu.sv
rtl/rv_ctrl.sv
rtl/rv_core.sv
verif/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - rtl/rv_core_pkg.sv
      - rtl/rv_regfile.sv
      - rtl/rv_alu.sv
      - rtl/rv_decode.sv
      - rtl/rv_lsu.sv
      - rtl/rv_ctrl.sv
      - rtl/rv_core.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_rv_core.sv
